/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f verilog.f \
		--top-module tbSparseMac -Mdir obj_dir -o tbSparseMac
	./obj_dir/tbSparseMac > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "Result: pass" || \
		(echo "Result: fail"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* hw/bufferMerge.sv */
`include "sparseMac_consts.svh"

// Appends the dense clusters behind the carry buffer
// A full pair goes to the MAC and the rest becomes the new buffer
module bufferMerge
	import sparseMacPkg::*;
(
	input  blockT currentBuffer,
	input  sizeT  currentSize,
	input  blockT denseClusters,
	input  rankT  numDense,
	output blockT macClusters,
	output logic  macValid,
	output blockT nextBuffer,
	output sizeT  nextSize
);

	// Buffer plus one full block
	localparam int lineSlots = 2 * `transferSize;

	rankT totalSize;

	// Zero padded sources so every slot index stays in range
	clusterT [lineSlots-1:0] paddedBuffer;
	clusterT [lineSlots-1:0] paddedDense;
	clusterT [lineSlots-1:0] mergedLine;

	//==================================================
	// Size logic
	//==================================================

	assign totalSize = rankT'(currentSize) + numDense;

	// Carry out of the total means a full pair is ready
	assign macValid = totalSize[`rankWidth-1];
	assign nextSize = totalSize[`sizeWidth-1:0];

	//==================================================
	// Concatenation
	//==================================================

	assign paddedBuffer = {blockT'('0), currentBuffer};
	assign paddedDense  = {blockT'('0), denseClusters};

	always_comb begin
		int denseIdx;

		for (int i = 0; i < lineSlots; i++) begin
			denseIdx = 0;
			if (i < int'(currentSize)) begin
				mergedLine[i] = paddedBuffer[i];
			end else if (i < int'(totalSize)) begin
				// Dense clusters start right after the buffered ones
				denseIdx = i - int'(currentSize);
				mergedLine[i] = paddedDense[denseIdx];
			end else begin
				mergedLine[i] = '0;
			end
		end
	end

	//==================================================
	// Split into MAC pair and new buffer
	//==================================================

	assign macClusters = mergedLine[`transferSize-1:0];

	// Leftover sits in the upper half only after a pair was taken
	assign nextBuffer = macValid ? mergedLine[lineSlots-1:`transferSize]
		: mergedLine[`transferSize-1:0];

endmodule

/* hw/denseFilter.sv */
`include "sparseMac_consts.svh"

// Packs the selected clusters of a block into the low slots
// A cluster with rank k+1 lands in output slot k
module denseFilter
	import sparseMacPkg::*;
(
	input  blockT   inputBlock,
	input  rankVecT rankVec,
	output blockT   denseClusters,
	output rankT    numDense
);

	//==================================================
	// Slot selection
	//==================================================

	always_comb begin
		for (int k = 0; k < `transferSize; k++) begin
			// Empty slots stay zero
			denseClusters[k] = '0;

			// Search runs downward so the lowest matching index wins
			for (int j = `transferSize - 1; j >= 0; j--) begin
				if (rankVec[j] == rankT'(k + 1)) begin
					denseClusters[k] = inputBlock[j];
				end
			end
		end
	end

	//==================================================
	// Selected count
	//==================================================

	// Rank of the top mask bit is the number of selected clusters
	assign numDense = rankVec[`transferSize-1];

endmodule

/* hw/maskAccumulator.sv */
`include "sparseMac_consts.svh"

// Running rank of every set bit in the select mask
// Bit 0 is counted first, so bit N sees all bits below it
module maskAccumulator
	import sparseMacPkg::*;
(
	input  logic [`transferSize-1:0] selectMask,
	output rankVecT                  rankVec
);

	//==================================================
	// Counter chain
	//==================================================

	always_comb begin
		rankT prevRank;
		rankT baseRank;

		prevRank = '0;
		for (int i = 0; i < `transferSize; i++) begin
			// A full block wraps the count back to zero
			if (prevRank == rankT'(`transferSize)) begin
				baseRank = '0;
			end else begin
				baseRank = prevRank;
			end

			rankVec[i] = baseRank + rankT'(selectMask[i]);

			// Feeds the next counter up the chain
			prevRank = rankVec[i];
		end
	end

endmodule

/* hw/sparseMacBufferUpdate.sv */
`include "sparseMac_consts.svh"

// Buffer update step of the sparse MAC datapath
// Mask rank, dense packing and buffer merge in one cycle, then registered
module sparseMacBufferUpdate
	import sparseMacPkg::*;
(
	input  logic                     clock,
	input  logic                     rstN,
	input  logic                     ivalid,
	input  logic [`transferSize-1:0] selectMask,
	input  blockT                    inputBlock,
	input  blockT                    currentBuffer,
	input  sizeT                     currentSize,
	output logic                     ovalid,
	output blockT                    macClusters,
	output logic                     macValid,
	output blockT                    nextBuffer,
	output sizeT                     nextSize
);

	rankVecT rankVec;
	blockT   denseClusters;
	rankT    numDense;

	// Combinational merge results ahead of the output register
	blockT mergeMacClusters;
	logic  mergeMacValid;
	blockT mergeNextBuffer;
	sizeT  mergeNextSize;

	//==================================================
	// Combinational stages
	//==================================================

	maskAccumulator maskAccum (
		.selectMask (selectMask),
		.rankVec    (rankVec)
	);

	denseFilter clusterFilter (
		.inputBlock    (inputBlock),
		.rankVec       (rankVec),
		.denseClusters (denseClusters),
		.numDense      (numDense)
	);

	bufferMerge merge (
		.currentBuffer (currentBuffer),
		.currentSize   (currentSize),
		.denseClusters (denseClusters),
		.numDense      (numDense),
		.macClusters   (mergeMacClusters),
		.macValid      (mergeMacValid),
		.nextBuffer    (mergeNextBuffer),
		.nextSize      (mergeNextSize)
	);

	//==================================================
	// Output register
	//==================================================

	// Strobe follows ivalid every cycle
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ovalid <= 1'b0;
		end else begin
			ovalid <= ivalid;
		end
	end

	// Results hold their value through idle cycles
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			macClusters <= '0;
			macValid    <= 1'b0;
			nextBuffer  <= '0;
			nextSize    <= '0;
		end else if (ivalid) begin
			macClusters <= mergeMacClusters;
			macValid    <= mergeMacValid;
			nextBuffer  <= mergeNextBuffer;
			nextSize    <= mergeNextSize;
		end
	end

endmodule

/* hw/sparseMacPkg.sv */
`include "sparseMac_consts.svh"

package sparseMacPkg;

	//==================================================
	// Payload types
	//==================================================

	// One weight cluster
	typedef logic [`clusterWidth-1:0] clusterT;

	// A full transfer block, slot 0 in the low bits
	// Also used for the carry buffer, the dense clusters and the MAC pair
	typedef clusterT [`transferSize-1:0] blockT;

	//==================================================
	// Count types
	//==================================================

	// Running rank of one mask bit
	typedef logic [`rankWidth-1:0] rankT;

	// One rank per mask bit, element i belongs to mask bit i
	typedef rankT [`transferSize-1:0] rankVecT;

	// Number of clusters waiting in the carry buffer
	typedef logic [`sizeWidth-1:0] sizeT;

endpackage

/* hw/sparseMac_consts.svh */
`ifndef sparseMacConstsSvh
`define sparseMacConstsSvh

//==================================================
// Transfer block geometry
//==================================================

// Clusters per transfer block, also the carry buffer capacity
`define transferSize 2

// Bits per weight cluster
`define clusterWidth 32

//==================================================
// Count widths
//==================================================

// Saturating rank, log2 of the transfer size plus one
`define rankWidth 2

// Carry buffer occupancy
// One bit narrower than a rank since a full buffer is always flushed
`define sizeWidth 1

`endif

/* testbench/clockGen.sv */
// Free running clock and power-on reset for the testbench
module clockGen (
	output logic clock,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int halfPeriod = 20;

	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	// Reset covers the first two rising edges, released on the falling edge after them
	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
	end

endmodule

/* testbench/tbSparseMac.sv */
`include "sparseMac_consts.svh"

module tbSparseMac
	import sparseMacPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clockPeriod  = 40;
	localparam int directedRows = 10;
	localparam int randomRows   = 16;
	localparam int numRows      = directedRows + randomRows;
	// Table length plus margin for reset and pipeline drain
	localparam int timeoutCycles = numRows + 20;

	// Wide enough for the largest output
	typedef logic [`transferSize*`clusterWidth-1:0] checkWordT;

	logic                     clock;
	logic                     rstN;
	logic                     ivalid;
	logic [`transferSize-1:0] selectMask;
	blockT                    inputBlock;
	blockT                    currentBuffer;
	sizeT                     currentSize;
	logic                     ovalid;
	blockT                    macClusters;
	logic                     macValid;
	blockT                    nextBuffer;
	sizeT                     nextSize;

	// Stimulus columns
	logic                     tabIvalid [numRows];
	logic [`transferSize-1:0] tabMask [numRows];
	blockT                    tabBlock [numRows];
	blockT                    tabBuffer [numRows];
	sizeT                     tabSize [numRows];

	// Expected columns as seen one edge after the row is sampled
	logic  expOvalid [numRows];
	blockT expMac [numRows];
	logic  expMacValid [numRows];
	blockT expNextBuffer [numRows];
	sizeT  expNextSize [numRows];

	int    seed;
	int    errorCount;
	int    checkCount;
	int    testCount;
	int    failedTests;
	string testName;

	clockGen clockSource (
		.clock (clock),
		.rstN  (rstN)
	);

	sparseMacBufferUpdate dut (
		.clock         (clock),
		.rstN          (rstN),
		.ivalid        (ivalid),
		.selectMask    (selectMask),
		.inputBlock    (inputBlock),
		.currentBuffer (currentBuffer),
		.currentSize   (currentSize),
		.ovalid        (ovalid),
		.macClusters   (macClusters),
		.macValid      (macValid),
		.nextBuffer    (nextBuffer),
		.nextSize      (nextSize)
	);

	//==================================================
	// Reference model
	//==================================================

	// Buffered clusters first, then selected clusters in mask order, then zeros
	task automatic referenceUpdate(
		input  logic [`transferSize-1:0] mask,
		input  blockT                    block,
		input  blockT                    buffer,
		input  sizeT                     size,
		output blockT                    macOut,
		output logic                     validOut,
		output blockT                    bufferOut,
		output sizeT                     sizeOut
	);
		clusterT line [2*`transferSize];
		int      fill;

		for (int i = 0; i < 2 * `transferSize; i++) begin
			line[i] = '0;
		end
		fill = 0;
		for (int i = 0; i < int'(size); i++) begin
			line[fill] = buffer[i];
			fill++;
		end
		for (int i = 0; i < `transferSize; i++) begin
			if (mask[i]) begin
				line[fill] = block[i];
				fill++;
			end
		end

		// A full pair leaves for the MAC and the remainder shifts down
		validOut = (fill >= `transferSize);
		for (int i = 0; i < `transferSize; i++) begin
			macOut[i]    = line[i];
			bufferOut[i] = validOut ? line[i + `transferSize] : line[i];
		end
		sizeOut = sizeT'(validOut ? fill - `transferSize : fill);
	endtask

	//==================================================
	// Table construction
	//==================================================

	task automatic setRow(
		input int                       idx,
		input logic                     valid,
		input logic [`transferSize-1:0] mask,
		input clusterT                  in0,
		input clusterT                  in1,
		input clusterT                  buf0,
		input clusterT                  buf1,
		input sizeT                     size
	);
		tabIvalid[idx] = valid;
		tabMask[idx]   = mask;
		tabBlock[idx]  = {in1, in0};
		tabBuffer[idx] = {buf1, buf0};
		tabSize[idx]   = size;
	endtask

	task automatic buildDirectedRows();
		clusterT a;
		clusterT b;
		clusterT c;
		clusterT d;

		a = 32'h1111_0001;
		b = 32'h2222_0002;
		c = 32'hCCCC_000C;
		// Junk in buffer slots past currentSize
		d = 32'hDEAD_BEEF;

		// Empty buffer with one or both selected
		setRow(0, 1'b1, 2'b01, a, b, 32'h0, 32'h0, 1'b0);
		setRow(1, 1'b1, 2'b10, a, b, 32'h0, 32'h0, 1'b0);
		setRow(2, 1'b1, 2'b11, a, b, 32'h0, 32'h0, 1'b0);
		// One cluster waiting
		setRow(3, 1'b1, 2'b01, a, b, c, d, 1'b1);
		setRow(4, 1'b1, 2'b10, a, b, c, d, 1'b1);
		setRow(5, 1'b1, 2'b11, a, b, c, d, 1'b1);
		// Idle rows whose outputs must hold
		setRow(6, 1'b0, 2'b11, d, c, a, b, 1'b0);
		setRow(7, 1'b0, 2'b01, b, a, c, c, 1'b1);
		// Nothing selected
		setRow(8, 1'b1, 2'b00, a, b, d, d, 1'b0);
		setRow(9, 1'b1, 2'b00, a, b, c, d, 1'b1);
	endtask

	task automatic buildRandomRows();
		logic [31:0] randWord;

		for (int r = directedRows; r < numRows; r++) begin
			randWord = $random(seed);
			// About one row in four is idle
			tabIvalid[r] = (randWord[9:8] != 2'b00);
			tabMask[r]   = randWord[`transferSize-1:0];
			tabSize[r]   = randWord[4 +: `sizeWidth];
			for (int i = 0; i < `transferSize; i++) begin
				tabBlock[r][i]  = $random(seed);
				tabBuffer[r][i] = $random(seed);
			end
		end
	endtask

	task automatic fillExpected();
		blockT heldMac;
		logic  heldValid;
		blockT heldBuffer;
		sizeT  heldSize;

		// Register contents right after reset
		heldMac    = '0;
		heldValid  = 1'b0;
		heldBuffer = '0;
		heldSize   = '0;
		for (int r = 0; r < numRows; r++) begin
			if (tabIvalid[r]) begin
				referenceUpdate(tabMask[r], tabBlock[r], tabBuffer[r], tabSize[r],
					heldMac, heldValid, heldBuffer, heldSize);
			end
			expOvalid[r]     = tabIvalid[r];
			expMac[r]        = heldMac;
			expMacValid[r]   = heldValid;
			expNextBuffer[r] = heldBuffer;
			expNextSize[r]   = heldSize;
		end
	endtask

	//==================================================
	// Checking and reporting
	//==================================================

	task automatic checkValue(input string name, input checkWordT actual,
		input checkWordT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERR %s %s: got 0x%0h, expected 0x%0h", testName, name, actual, expected);
		end
	endtask

	task automatic reportTest(input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("%s: ok", testName);
		end else begin
			failedTests++;
			$display("%s: %0d mismatches", testName, errorCount - errorsBefore);
		end
	endtask

	task automatic checkResetState();
		int errorsBefore;

		errorsBefore = errorCount;
		checkValue("ovalid", checkWordT'(ovalid), '0);
		checkValue("macValid", checkWordT'(macValid), '0);
		checkValue("nextSize", checkWordT'(nextSize), '0);
		checkValue("macClusters", checkWordT'(macClusters), '0);
		checkValue("nextBuffer", checkWordT'(nextBuffer), '0);
		reportTest(errorsBefore);
	endtask

	task automatic checkRow(input int r);
		int errorsBefore;

		errorsBefore = errorCount;
		testName = $sformatf("row %0d %s ivalid=%0b", r,
			(r < directedRows) ? "directed" : "random", tabIvalid[r]);
		checkValue("ovalid", checkWordT'(ovalid), checkWordT'(expOvalid[r]));
		checkValue("macValid", checkWordT'(macValid), checkWordT'(expMacValid[r]));
		checkValue("macClusters", checkWordT'(macClusters), checkWordT'(expMac[r]));
		checkValue("nextBuffer", checkWordT'(nextBuffer), checkWordT'(expNextBuffer[r]));
		checkValue("nextSize", checkWordT'(nextSize), checkWordT'(expNextSize[r]));
		reportTest(errorsBefore);
	endtask

	task automatic applyRow(input int r);
		ivalid        <= tabIvalid[r];
		selectMask    <= tabMask[r];
		inputBlock    <= tabBlock[r];
		currentBuffer <= tabBuffer[r];
		currentSize   <= tabSize[r];
	endtask

	//==================================================
	// Main sequence
	//==================================================

	initial begin
		seed        = 52;
		errorCount  = 0;
		checkCount  = 0;
		testCount   = 0;
		failedTests = 0;
		testName    = "";

		ivalid        <= 1'b0;
		selectMask    <= '0;
		inputBlock    <= '0;
		currentBuffer <= '0;
		currentSize   <= '0;

		buildDirectedRows();
		buildRandomRows();
		fillExpected();

		// Middle of the first reset cycle
		@(posedge clock);
		@(negedge clock);
		testName = "reset held";
		checkResetState();

		// First edge after release, still idle
		wait (rstN === 1'b1);
		@(posedge clock);
		@(negedge clock);
		testName = "reset release";
		checkResetState();

		// Row r is driven on one edge and checked after the next
		for (int r = 0; r <= numRows; r++) begin
			@(posedge clock);
			if (r < numRows) begin
				applyRow(r);
			end else begin
				ivalid <= 1'b0;
			end
			if (r > 0) begin
				@(negedge clock);
				checkRow(r - 1);
			end
		end

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(timeoutCycles * clockPeriod);
		$display("timeout: the run did not finish within %0d clock cycles", timeoutCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+hw
hw/sparseMacPkg.sv
hw/maskAccumulator.sv
hw/denseFilter.sv
hw/bufferMerge.sv
hw/sparseMacBufferUpdate.sv
testbench/clockGen.sv
testbench/tbSparseMac.sv
